/* source/axi_mem_pkg.sv */
`default_nettype none

package axi_mem_pkg;

  // Number of AXI slave ports
  localparam int unsigned NUM_PORTS = 2;
  // Number of SRAM banks behind the crossbar
  localparam int unsigned NUM_BANKS = 4;
  // Bank words per 64-bit AXI beat
  localparam int unsigned LANES_PER_CHANNEL = 2;
  // Crossbar inputs, a read and a write channel per port
  localparam int unsigned NUM_LANES = NUM_PORTS * 2 * LANES_PER_CHANNEL;
  // Bank read latency in cycles
  localparam int unsigned MEM_LATENCY = 1;

  // AXI side
  typedef logic [11:0] axi_addr_t;
  typedef logic [63:0] axi_data_t;
  typedef logic [7:0]  axi_strb_t;

  // Bank side
  typedef logic [7:0]  bank_addr_t;
  typedef logic [31:0] bank_data_t;
  typedef logic [3:0]  bank_strb_t;

  // Crossbar input index
  typedef logic [2:0]  lane_idx_t;

  // Word splitter FSM
  typedef enum logic [1:0] {
    SPLIT_IDLE    = 2'd0,
    SPLIT_ISSUE   = 2'd1,
    SPLIT_RESPOND = 2'd2
  } splitter_state_e;

endpackage

`default_nettype wire

/* source/access_chan_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface access_chan_if;
  import axi_mem_pkg::*;

  // Request, held stable while req_valid is high
  logic      req_valid;
  logic      req_ready;
  axi_addr_t addr;
  axi_data_t wdata;
  axi_strb_t strb;

  // Response, zero data on the write channel
  logic      rsp_valid;
  logic      rsp_ready;
  axi_data_t rdata;

  modport port_side (
    output req_valid, addr, wdata, strb, rsp_ready,
    input  req_ready, rsp_valid, rdata
  );

  modport splitter_side (
    input  req_valid, addr, wdata, strb, rsp_ready,
    output req_ready, rsp_valid, rdata
  );

endinterface

`default_nettype wire

/* source/bank_lane_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface bank_lane_if;
  import axi_mem_pkg::*;

  // Lane requests, one entry per bank word of the beat
  logic       [LANES_PER_CHANNEL-1:0] lane_req;
  bank_addr_t [LANES_PER_CHANNEL-1:0] row;
  // Bank pair select from address bit 3
  logic       [LANES_PER_CHANNEL-1:0] bank_pair;
  bank_data_t [LANES_PER_CHANNEL-1:0] wdata;
  bank_strb_t [LANES_PER_CHANNEL-1:0] strb;

  // Grant and return, one cycle apart
  logic       [LANES_PER_CHANNEL-1:0] lane_gnt;
  logic       [LANES_PER_CHANNEL-1:0] lane_rvalid;
  bank_data_t [LANES_PER_CHANNEL-1:0] lane_rdata;

  modport splitter_side (
    output lane_req, row, bank_pair, wdata, strb,
    input  lane_gnt, lane_rvalid, lane_rdata
  );

  modport xbar_side (
    input  lane_req, row, bank_pair, wdata, strb,
    output lane_gnt, lane_rvalid, lane_rdata
  );

endinterface

`default_nettype wire

/* source/axi_port_split.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_port_split (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // AW and W, accepted as one request
  input  logic                   awvalid_i,
  input  axi_mem_pkg::axi_addr_t awaddr_i,
  output logic                   awready_o,
  input  logic                   wvalid_i,
  input  axi_mem_pkg::axi_data_t wdata_i,
  input  axi_mem_pkg::axi_strb_t wstrb_i,
  output logic                   wready_o,
  output logic                   bvalid_o,
  input  logic                   bready_i,
  // AR and R
  input  logic                   arvalid_i,
  input  axi_mem_pkg::axi_addr_t araddr_i,
  output logic                   arready_o,
  output logic                   rvalid_o,
  output axi_mem_pkg::axi_data_t rdata_o,
  input  logic                   rready_i,
  // Toward the word splitters
  access_chan_if.port_side       wr_o,
  access_chan_if.port_side       rd_o
);

  // One outstanding request per channel
  logic wr_busy_q;
  logic rd_busy_q;

  // Write request only when both AW and W are present
  assign wr_o.req_valid = awvalid_i && wvalid_i && !wr_busy_q;
  assign wr_o.addr      = awaddr_i;
  assign wr_o.wdata     = wdata_i;
  assign wr_o.strb      = wstrb_i;
  // Same cycle ready for AW and W
  assign awready_o      = wr_o.req_valid && wr_o.req_ready;
  assign wready_o       = awready_o;
  assign bvalid_o       = wr_o.rsp_valid;
  assign wr_o.rsp_ready = bready_i;

  // Read channel carries no payload data
  assign rd_o.req_valid = arvalid_i && !rd_busy_q;
  assign rd_o.addr      = araddr_i;
  assign rd_o.wdata     = '0;
  assign rd_o.strb      = '0;
  assign arready_o      = rd_o.req_valid && rd_o.req_ready;
  assign rvalid_o       = rd_o.rsp_valid;
  assign rdata_o        = rd_o.rdata;
  assign rd_o.rsp_ready = rready_i;

  // Set on accept, cleared when B or R is taken
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_busy_q <= 1'b0;
      rd_busy_q <= 1'b0;
    end else begin
      if (awready_o) begin
        wr_busy_q <= 1'b1;
      end else if (wr_o.rsp_valid && bready_i) begin
        wr_busy_q <= 1'b0;
      end
      if (arready_o) begin
        rd_busy_q <= 1'b1;
      end else if (rd_o.rsp_valid && rready_i) begin
        rd_busy_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* source/word_splitter.sv */
`timescale 1ns/1ps
`default_nettype none

module word_splitter #(
  // Set on the write channel, where returns carry no data
  parameter bit WRITE_CHANNEL = 1'b1
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  access_chan_if.splitter_side chan_i,
  bank_lane_if.splitter_side   lanes_o
);
  import axi_mem_pkg::*;

  splitter_state_e state_q;

  // Latched request
  axi_addr_t addr_q;
  axi_data_t wdata_q;
  axi_strb_t strb_q;
  // Gathered lane returns
  axi_data_t rdata_q;

  // Per-lane progress flags
  logic [LANES_PER_CHANNEL-1:0] gnt_q;
  logic [LANES_PER_CHANNEL-1:0] ret_q;
  // Returns seen so far, including this cycle
  logic [LANES_PER_CHANNEL-1:0] ret_all;

  assign ret_all = ret_q | lanes_o.lane_rvalid;

  // New request only from idle
  assign chan_i.req_ready = (state_q == SPLIT_IDLE);
  assign chan_i.rsp_valid = (state_q == SPLIT_RESPOND);
  assign chan_i.rdata     = rdata_q;

  // Lane j holds bits [32j+31:32j] of the beat
  for (genvar j = 0; j < LANES_PER_CHANNEL; j++) begin : gen_lane
    // Request drops once granted
    assign lanes_o.lane_req[j]  = (state_q == SPLIT_ISSUE) && !gnt_q[j];
    // Row from bits 11:4, bank pair from bit 3, byte offset ignored
    assign lanes_o.row[j]       = addr_q[11:4];
    assign lanes_o.bank_pair[j] = addr_q[3];
    assign lanes_o.wdata[j]     = wdata_q[j*$bits(bank_data_t) +: $bits(bank_data_t)];
    assign lanes_o.strb[j]      = strb_q[j*$bits(bank_strb_t) +: $bits(bank_strb_t)];
  end

  // Control FSM
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= SPLIT_IDLE;
      gnt_q   <= '0;
      ret_q   <= '0;
    end else begin
      case (state_q)
        SPLIT_IDLE: begin
          if (chan_i.req_valid) begin
            state_q <= SPLIT_ISSUE;
            gnt_q   <= '0;
            ret_q   <= '0;
          end
        end
        SPLIT_ISSUE: begin
          gnt_q <= gnt_q | (lanes_o.lane_req & lanes_o.lane_gnt);
          ret_q <= ret_all;
          // Respond in the cycle after the last return
          if (&ret_all) begin
            state_q <= SPLIT_RESPOND;
          end
        end
        SPLIT_RESPOND: begin
          if (chan_i.rsp_ready) begin
            state_q <= SPLIT_IDLE;
          end
        end
        default: begin
          state_q <= SPLIT_IDLE;
        end
      endcase
    end
  end

  // Payload capture
  always_ff @(posedge clk_i) begin
    if (chan_i.req_valid && chan_i.req_ready) begin
      addr_q  <= chan_i.addr;
      wdata_q <= chan_i.wdata;
      strb_q  <= chan_i.strb;
    end
    for (int j = 0; j < LANES_PER_CHANNEL; j++) begin
      if (lanes_o.lane_rvalid[j]) begin
        // Write acks come back as zero data
        rdata_q[j*$bits(bank_data_t) +: $bits(bank_data_t)] <=
          WRITE_CHANNEL ? '0 : lanes_o.lane_rdata[j];
      end
    end
  end

endmodule

`default_nettype wire

/* source/bank_crossbar.sv */
`timescale 1ns/1ps
`default_nettype none

module bank_crossbar (
  input  logic                                                   clk_i,
  input  logic                                                   rst_n_i,
  // Port 0 write, port 0 read, port 1 write, port 1 read
  bank_lane_if.xbar_side                                         ch0_i,
  bank_lane_if.xbar_side                                         ch1_i,
  bank_lane_if.xbar_side                                         ch2_i,
  bank_lane_if.xbar_side                                         ch3_i,
  // SRAM banks
  output logic                   [axi_mem_pkg::NUM_BANKS-1:0]    mem_req_o,
  input  logic                   [axi_mem_pkg::NUM_BANKS-1:0]    mem_gnt_i,
  output axi_mem_pkg::bank_addr_t [axi_mem_pkg::NUM_BANKS-1:0]   mem_addr_o,
  output logic                   [axi_mem_pkg::NUM_BANKS-1:0]    mem_we_o,
  output axi_mem_pkg::bank_data_t [axi_mem_pkg::NUM_BANKS-1:0]   mem_wdata_o,
  output axi_mem_pkg::bank_strb_t [axi_mem_pkg::NUM_BANKS-1:0]   mem_be_o,
  input  axi_mem_pkg::bank_data_t [axi_mem_pkg::NUM_BANKS-1:0]   mem_rdata_i
);
  import axi_mem_pkg::*;

  // Flat lane view, lane index is channel * 2 + lane
  logic       [NUM_LANES-1:0] in_req;
  logic       [NUM_LANES-1:0] in_pair;
  bank_addr_t [NUM_LANES-1:0] in_row;
  bank_data_t [NUM_LANES-1:0] in_wdata;
  bank_strb_t [NUM_LANES-1:0] in_strb;
  logic       [NUM_LANES-1:0] in_gnt;
  logic       [NUM_LANES-1:0] in_rvalid;
  bank_data_t [NUM_LANES-1:0] in_rdata;

  // Lanes requesting each bank
  logic [NUM_BANKS-1:0][NUM_LANES-1:0] bank_hit;
  // Round-robin pointer and current winner per bank
  lane_idx_t [NUM_BANKS-1:0] rr_q;
  lane_idx_t [NUM_BANKS-1:0] winner;
  // Return pipeline, one stage per cycle of bank latency
  logic      [NUM_BANKS-1:0][MEM_LATENCY-1:0] ret_vld_q;
  lane_idx_t [NUM_BANKS-1:0][MEM_LATENCY-1:0] ret_idx_q;

  assign in_req   = {ch3_i.lane_req, ch2_i.lane_req, ch1_i.lane_req, ch0_i.lane_req};
  assign in_pair  = {ch3_i.bank_pair, ch2_i.bank_pair, ch1_i.bank_pair, ch0_i.bank_pair};
  assign in_row   = {ch3_i.row, ch2_i.row, ch1_i.row, ch0_i.row};
  assign in_wdata = {ch3_i.wdata, ch2_i.wdata, ch1_i.wdata, ch0_i.wdata};
  assign in_strb  = {ch3_i.strb, ch2_i.strb, ch1_i.strb, ch0_i.strb};
  assign {ch3_i.lane_gnt, ch2_i.lane_gnt, ch1_i.lane_gnt, ch0_i.lane_gnt} = in_gnt;
  assign {ch3_i.lane_rvalid, ch2_i.lane_rvalid, ch1_i.lane_rvalid, ch0_i.lane_rvalid} = in_rvalid;
  assign {ch3_i.lane_rdata, ch2_i.lane_rdata, ch1_i.lane_rdata, ch0_i.lane_rdata} = in_rdata;

  // Lane j of a beat targets bank pair * 2 + j
  for (genvar l = 0; l < NUM_LANES; l++) begin : gen_lane_target
    for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
      assign bank_hit[b][l] = in_req[l] && (in_pair[l] == 1'(b / LANES_PER_CHANNEL)) &&
                              ((l % LANES_PER_CHANNEL) == (b % LANES_PER_CHANNEL));
    end
  end

  // Arbitration, search starts at the pointer and wraps
  always_comb begin
    lane_idx_t cand;
    logic      found;
    for (int b = 0; b < NUM_BANKS; b++) begin
      found     = 1'b0;
      winner[b] = rr_q[b];
      for (int k = 0; k < NUM_LANES; k++) begin
        cand = rr_q[b] + lane_idx_t'(k);
        if (!found && bank_hit[b][cand]) begin
          found     = 1'b1;
          winner[b] = cand;
        end
      end
      mem_req_o[b]   = found;
      mem_addr_o[b]  = in_row[winner[b]];
      // Even channels are writes, channel LSB sits at lane index bit 1
      mem_we_o[b]    = !winner[b][1];
      mem_wdata_o[b] = in_wdata[winner[b]];
      mem_be_o[b]    = in_strb[winner[b]];
    end
  end

  // Lane grant follows the bank grant in the same cycle
  always_comb begin
    in_gnt = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (mem_req_o[b] && mem_gnt_i[b]) begin
        in_gnt[winner[b]] = 1'b1;
      end
    end
  end

  // Route bank data to the lane that won it
  always_comb begin
    in_rvalid = '0;
    in_rdata  = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (ret_vld_q[b][MEM_LATENCY-1]) begin
        in_rvalid[ret_idx_q[b][MEM_LATENCY-1]] = 1'b1;
        in_rdata[ret_idx_q[b][MEM_LATENCY-1]]  = mem_rdata_i[b];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q      <= '0;
      ret_vld_q <= '0;
    end else begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        // Pointer moves past the winner
        if (mem_req_o[b] && mem_gnt_i[b]) begin
          rr_q[b] <= winner[b] + lane_idx_t'(1);
        end
        ret_vld_q[b][0] <= mem_req_o[b] && mem_gnt_i[b];
        for (int s = 1; s < MEM_LATENCY; s++) begin
          ret_vld_q[b][s] <= ret_vld_q[b][s-1];
        end
      end
    end
  end

  // Winner index follows the valid through the pipeline
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      ret_idx_q[b][0] <= winner[b];
      for (int s = 1; s < MEM_LATENCY; s++) begin
        ret_idx_q[b][s] <= ret_idx_q[b][s-1];
      end
    end
  end

endmodule

`default_nettype wire

/* source/axi_banked_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_banked_mem (
  input  logic                                                 clk_i,
  input  logic                                                 rst_n_i,
  // AXI slave ports
  input  logic                   [axi_mem_pkg::NUM_PORTS-1:0]  s_awvalid_i,
  input  axi_mem_pkg::axi_addr_t [axi_mem_pkg::NUM_PORTS-1:0]  s_awaddr_i,
  output logic                   [axi_mem_pkg::NUM_PORTS-1:0]  s_awready_o,
  input  logic                   [axi_mem_pkg::NUM_PORTS-1:0]  s_wvalid_i,
  input  axi_mem_pkg::axi_data_t [axi_mem_pkg::NUM_PORTS-1:0]  s_wdata_i,
  input  axi_mem_pkg::axi_strb_t [axi_mem_pkg::NUM_PORTS-1:0]  s_wstrb_i,
  output logic                   [axi_mem_pkg::NUM_PORTS-1:0]  s_wready_o,
  output logic                   [axi_mem_pkg::NUM_PORTS-1:0]  s_bvalid_o,
  input  logic                   [axi_mem_pkg::NUM_PORTS-1:0]  s_bready_i,
  input  logic                   [axi_mem_pkg::NUM_PORTS-1:0]  s_arvalid_i,
  input  axi_mem_pkg::axi_addr_t [axi_mem_pkg::NUM_PORTS-1:0]  s_araddr_i,
  output logic                   [axi_mem_pkg::NUM_PORTS-1:0]  s_arready_o,
  output logic                   [axi_mem_pkg::NUM_PORTS-1:0]  s_rvalid_o,
  output axi_mem_pkg::axi_data_t [axi_mem_pkg::NUM_PORTS-1:0]  s_rdata_o,
  input  logic                   [axi_mem_pkg::NUM_PORTS-1:0]  s_rready_i,
  // SRAM banks
  output logic                    [axi_mem_pkg::NUM_BANKS-1:0] mem_req_o,
  input  logic                    [axi_mem_pkg::NUM_BANKS-1:0] mem_gnt_i,
  output axi_mem_pkg::bank_addr_t [axi_mem_pkg::NUM_BANKS-1:0] mem_addr_o,
  output logic                    [axi_mem_pkg::NUM_BANKS-1:0] mem_we_o,
  output axi_mem_pkg::bank_data_t [axi_mem_pkg::NUM_BANKS-1:0] mem_wdata_o,
  output axi_mem_pkg::bank_strb_t [axi_mem_pkg::NUM_BANKS-1:0] mem_be_o,
  input  axi_mem_pkg::bank_data_t [axi_mem_pkg::NUM_BANKS-1:0] mem_rdata_i
);
  import axi_mem_pkg::*;

  // Channel 2p is the write side of port p, 2p+1 the read side
  access_chan_if chan [NUM_PORTS*2] ();
  bank_lane_if   lanes [NUM_PORTS*2] ();

  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
    axi_port_split i_axi_port_split (
      .clk_i     ( clk_i          ),
      .rst_n_i   ( rst_n_i        ),
      .awvalid_i ( s_awvalid_i[p] ),
      .awaddr_i  ( s_awaddr_i[p]  ),
      .awready_o ( s_awready_o[p] ),
      .wvalid_i  ( s_wvalid_i[p]  ),
      .wdata_i   ( s_wdata_i[p]   ),
      .wstrb_i   ( s_wstrb_i[p]   ),
      .wready_o  ( s_wready_o[p]  ),
      .bvalid_o  ( s_bvalid_o[p]  ),
      .bready_i  ( s_bready_i[p]  ),
      .arvalid_i ( s_arvalid_i[p] ),
      .araddr_i  ( s_araddr_i[p]  ),
      .arready_o ( s_arready_o[p] ),
      .rvalid_o  ( s_rvalid_o[p]  ),
      .rdata_o   ( s_rdata_o[p]   ),
      .rready_i  ( s_rready_i[p]  ),
      .wr_o      ( chan[2*p]      ),
      .rd_o      ( chan[2*p+1]    )
    );
  end

  // One splitter per channel, even channels write
  for (genvar k = 0; k < NUM_PORTS*2; k++) begin : gen_splitter
    word_splitter #(
      .WRITE_CHANNEL ( (k % 2) == 0 )
    ) i_word_splitter (
      .clk_i   ( clk_i    ),
      .rst_n_i ( rst_n_i  ),
      .chan_i  ( chan[k]  ),
      .lanes_o ( lanes[k] )
    );
  end

  bank_crossbar i_bank_crossbar (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .ch0_i       ( lanes[0]    ),
    .ch1_i       ( lanes[1]    ),
    .ch2_i       ( lanes[2]    ),
    .ch3_i       ( lanes[3]    ),
    .mem_req_o   ( mem_req_o   ),
    .mem_gnt_i   ( mem_gnt_i   ),
    .mem_addr_o  ( mem_addr_o  ),
    .mem_we_o    ( mem_we_o    ),
    .mem_wdata_o ( mem_wdata_o ),
    .mem_be_o    ( mem_be_o    ),
    .mem_rdata_i ( mem_rdata_i )
  );

endmodule

`default_nettype wire

/* test/axi_banked_mem_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_banked_mem_chk (
  input logic                                                 clk_i,
  input logic                                                 rst_n_i,
  // AXI side of both ports
  input logic                    [axi_mem_pkg::NUM_PORTS-1:0] awready_i,
  input logic                    [axi_mem_pkg::NUM_PORTS-1:0] wready_i,
  input logic                    [axi_mem_pkg::NUM_PORTS-1:0] bvalid_i,
  input logic                    [axi_mem_pkg::NUM_PORTS-1:0] bready_i,
  input logic                    [axi_mem_pkg::NUM_PORTS-1:0] rvalid_i,
  input logic                    [axi_mem_pkg::NUM_PORTS-1:0] rready_i,
  input axi_mem_pkg::axi_data_t  [axi_mem_pkg::NUM_PORTS-1:0] rdata_i,
  // Bank side
  input logic                    [axi_mem_pkg::NUM_BANKS-1:0] mem_req_i,
  input logic                    [axi_mem_pkg::NUM_BANKS-1:0] mem_gnt_i,
  input axi_mem_pkg::bank_addr_t [axi_mem_pkg::NUM_BANKS-1:0] mem_addr_i,
  input logic                    [axi_mem_pkg::NUM_BANKS-1:0] mem_we_i,
  input axi_mem_pkg::bank_data_t [axi_mem_pkg::NUM_BANKS-1:0] mem_wdata_i,
  input axi_mem_pkg::bank_strb_t [axi_mem_pkg::NUM_BANKS-1:0] mem_be_i
);
  import axi_mem_pkg::*;

  // Failed assertions so far, summed into the testbench result
  int unsigned viol_cnt = 0;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
    // AW and W always accepted in the same cycle
    assert property (@(posedge clk_i) disable iff (!rst_n_i) awready_i[p] == wready_i[p])
      else begin
        $error("port %0d: awready and wready differ", p);
        viol_cnt++;
      end

    // B held until taken
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      bvalid_i[p] && !bready_i[p] |=> bvalid_i[p])
      else begin
        $error("port %0d: bvalid dropped before bready", p);
        viol_cnt++;
      end

    // R and its data held until taken
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rvalid_i[p] && !rready_i[p] |=> rvalid_i[p] && $stable(rdata_i[p]))
      else begin
        $error("port %0d: rvalid or rdata changed before rready", p);
        viol_cnt++;
      end
  end

  // A granted access is not offered a second time
  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mem_req_i[b] && mem_gnt_i[b] |=> !mem_req_i[b] ||
        !$stable({mem_addr_i[b], mem_we_i[b], mem_wdata_i[b], mem_be_i[b]}))
      else begin
        $error("bank %0d: same request repeated after its grant", b);
        viol_cnt++;
      end
  end

endmodule

`default_nettype wire

/* test/tb_axi_banked_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_banked_mem;
  import axi_mem_pkg::*;

  localparam int unsigned SEED = 32'h3e4d_d9b7;
  localparam int CLK_PERIOD_NS = 10;
  localparam int RAND_ACCESSES = 200;
  // Generous bound for one access under random grants and ready
  localparam int CYCLES_PER_ACCESS = 30;
  localparam int WATCHDOG_NS = RAND_ACCESSES * CYCLES_PER_ACCESS * CLK_PERIOD_NS;
  localparam int ROWS = 256;
  localparam int BYTES = 1 << $bits(axi_addr_t);

  logic                         clk;
  logic                         rst_n;
  logic       [NUM_PORTS-1:0]   s_awvalid;
  axi_addr_t  [NUM_PORTS-1:0]   s_awaddr;
  logic       [NUM_PORTS-1:0]   s_awready;
  logic       [NUM_PORTS-1:0]   s_wvalid;
  axi_data_t  [NUM_PORTS-1:0]   s_wdata;
  axi_strb_t  [NUM_PORTS-1:0]   s_wstrb;
  logic       [NUM_PORTS-1:0]   s_wready;
  logic       [NUM_PORTS-1:0]   s_bvalid;
  logic       [NUM_PORTS-1:0]   s_bready;
  logic       [NUM_PORTS-1:0]   s_arvalid;
  axi_addr_t  [NUM_PORTS-1:0]   s_araddr;
  logic       [NUM_PORTS-1:0]   s_arready;
  logic       [NUM_PORTS-1:0]   s_rvalid;
  axi_data_t  [NUM_PORTS-1:0]   s_rdata;
  logic       [NUM_PORTS-1:0]   s_rready;
  logic       [NUM_BANKS-1:0]   mem_req;
  logic       [NUM_BANKS-1:0]   mem_gnt = '1;
  bank_addr_t [NUM_BANKS-1:0]   mem_addr;
  logic       [NUM_BANKS-1:0]   mem_we;
  bank_data_t [NUM_BANKS-1:0]   mem_wdata;
  bank_strb_t [NUM_BANKS-1:0]   mem_be;
  bank_data_t [NUM_BANKS-1:0]   mem_rdata = '0;

  // Bank model words and the flat byte reference
  bank_data_t bank_mem [NUM_BANKS][ROWS];
  bank_data_t rd_word [NUM_BANKS] = '{default: '0};
  logic [7:0] ref_mem [BYTES];

  // Random grants and ready only in the last test
  bit rand_mode = 1'b0;
  int err_cnt = 0;
  int check_cnt = 0;
  int test_num = 0;
  int fail_tests = 0;
  int test_base = 0;

  axi_banked_mem i_axi_banked_mem (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .s_awvalid_i ( s_awvalid ),
    .s_awaddr_i  ( s_awaddr  ),
    .s_awready_o ( s_awready ),
    .s_wvalid_i  ( s_wvalid  ),
    .s_wdata_i   ( s_wdata   ),
    .s_wstrb_i   ( s_wstrb   ),
    .s_wready_o  ( s_wready  ),
    .s_bvalid_o  ( s_bvalid  ),
    .s_bready_i  ( s_bready  ),
    .s_arvalid_i ( s_arvalid ),
    .s_araddr_i  ( s_araddr  ),
    .s_arready_o ( s_arready ),
    .s_rvalid_o  ( s_rvalid  ),
    .s_rdata_o   ( s_rdata   ),
    .s_rready_i  ( s_rready  ),
    .mem_req_o   ( mem_req   ),
    .mem_gnt_i   ( mem_gnt   ),
    .mem_addr_o  ( mem_addr  ),
    .mem_we_o    ( mem_we    ),
    .mem_wdata_o ( mem_wdata ),
    .mem_be_o    ( mem_be    ),
    .mem_rdata_i ( mem_rdata )
  );

  bind axi_banked_mem axi_banked_mem_chk i_axi_banked_mem_chk (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .awready_i   ( s_awready_o ),
    .wready_i    ( s_wready_o  ),
    .bvalid_i    ( s_bvalid_o  ),
    .bready_i    ( s_bready_i  ),
    .rvalid_i    ( s_rvalid_o  ),
    .rready_i    ( s_rready_i  ),
    .rdata_i     ( s_rdata_o   ),
    .mem_req_i   ( mem_req_o   ),
    .mem_gnt_i   ( mem_gnt_i   ),
    .mem_addr_i  ( mem_addr_o  ),
    .mem_we_i    ( mem_we_o    ),
    .mem_wdata_i ( mem_wdata_o ),
    .mem_be_i    ( mem_be_o    )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD_NS / 2) clk = ~clk;
  end

  // Bank model, byte enables on writes, word captured on reads
  always @(posedge clk) begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (mem_req[b] && mem_gnt[b]) begin
        if (mem_we[b]) begin
          for (int k = 0; k < 4; k++) begin
            if (mem_be[b][k]) begin
              bank_mem[b][mem_addr[b]][8*k +: 8] <= mem_wdata[b][8*k +: 8];
            end
          end
        end else begin
          rd_word[b] <= bank_mem[b][mem_addr[b]];
        end
      end
    end
  end

  // Read data and grants change on the falling edge
  always @(negedge clk) begin
    logic [31:0] r;
    r = $urandom;
    mem_gnt <= rand_mode ? r[NUM_BANKS-1:0] : '1;
    for (int b = 0; b < NUM_BANKS; b++) begin
      mem_rdata[b] <= rd_word[b];
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: no result after %0d ns, a handshake never completed", WATCHDOG_NS);
    $display("FAIL: see errors above");
    $finish;
  end

  // Initial byte value, mixes all twelve address bits
  function automatic logic [7:0] fill_byte(input axi_addr_t a);
    return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h5a;
  endfunction

  // Expected beat, byte offset bits ignored
  function automatic axi_data_t ref_beat(input axi_addr_t a);
    axi_data_t d;
    for (int i = 0; i < 8; i++) begin
      d[8*i +: 8] = ref_mem[{a[11:3], 3'(i)}];
    end
    return d;
  endfunction

  function automatic int total_errors();
    return err_cnt + int'(i_axi_banked_mem.i_axi_banked_mem_chk.viol_cnt);
  endfunction

  task automatic expect_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      $display("Error: %0t ns: %s gave %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = total_errors() - test_base;
    test_num++;
    if (errs != 0) begin
      fail_tests++;
    end
    $display("Test %0d %s: %s", test_num, name, (errs == 0) ? "ok" : "failed");
    test_base = total_errors();
  endtask

  // AW and W together, then wait for B
  task automatic write_beat(input int p, input axi_addr_t a, input axi_data_t d,
                            input axi_strb_t s);
    logic done;
    @(negedge clk);
    s_awvalid[p] = 1'b1;
    s_awaddr[p]  = a;
    s_wvalid[p]  = 1'b1;
    s_wdata[p]   = d;
    s_wstrb[p]   = s;
    s_bready[p]  = 1'b0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      done = s_awready[p];
    end
    // Reference follows the strobe
    for (int i = 0; i < 8; i++) begin
      if (s[i]) begin
        ref_mem[{a[11:3], 3'(i)}] = d[8*i +: 8];
      end
    end
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      s_awvalid[p] = 1'b0;
      s_wvalid[p]  = 1'b0;
      s_bready[p]  = rand_mode ? ($urandom % 2 == 1) : 1'b1;
      @(posedge clk);
      done = s_bvalid[p] && s_bready[p];
    end
  endtask

  // AR, then wait for R and compare
  task automatic read_beat(input int p, input axi_addr_t a);
    axi_data_t exp;
    axi_data_t got;
    logic done;
    @(negedge clk);
    s_arvalid[p] = 1'b1;
    s_araddr[p]  = a;
    s_rready[p]  = 1'b0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      done = s_arready[p];
    end
    exp = ref_beat(a);
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      s_arvalid[p] = 1'b0;
      s_rready[p]  = rand_mode ? ($urandom % 2 == 1) : 1'b1;
      @(posedge clk);
      done = s_rvalid[p] && s_rready[p];
      got  = s_rdata[p];
    end
    expect_eq($sformatf("port %0d read at %h", p, a), got, exp);
  endtask

  // Port p keeps to rows whose LSB is p, so the ports never share a row
  task automatic random_port(input int p, input int n);
    axi_addr_t a;
    for (int i = 0; i < n; i++) begin
      a = axi_addr_t'($urandom);
      a[4] = p[0];
      if ($urandom % 2 == 0) begin
        write_beat(p, a, {$urandom, $urandom}, axi_strb_t'($urandom));
      end else begin
        read_beat(p, a);
      end
    end
  endtask

  initial begin
    axi_addr_t a;
    void'($urandom(SEED));
    rst_n     = 1'b0;
    s_awvalid = '0;
    s_awaddr  = '0;
    s_wvalid  = '0;
    s_wdata   = '0;
    s_wstrb   = '0;
    s_bready  = '0;
    s_arvalid = '0;
    s_araddr  = '0;
    s_rready  = '0;
    // Lane j of a beat at bank pair*2+j, row from bits 11:4
    for (int i = 0; i < BYTES; i++) begin
      a = axi_addr_t'(i);
      ref_mem[a] = fill_byte(a);
      bank_mem[{a[3], a[2]}][a[11:4]][8*a[1:0] +: 8] = fill_byte(a);
    end

    repeat (2) begin
      @(negedge clk);
      expect_eq("outputs in reset",
                64'({s_awready, s_wready, s_bvalid, s_arready, s_rvalid, mem_req}), 64'd0);
    end
    rst_n = 1'b1;
    repeat (3) begin
      @(negedge clk);
      expect_eq("outputs while idle",
                64'({s_awready, s_wready, s_bvalid, s_arready, s_rvalid, mem_req}), 64'd0);
    end
    finish_test("reset");

    write_beat(0, 12'h010, 64'h0123_4567_89ab_cdef, 8'hff);
    read_beat(0, 12'h010);
    // Offset bits set, still the pair 1 beat
    write_beat(0, 12'h01c, 64'hfedc_ba98_7654_3210, 8'hff);
    read_beat(0, 12'h018);
    finish_test("write then read");

    write_beat(0, 12'h010, 64'h1111_2222_3333_4444, 8'b1010_0101);
    read_beat(0, 12'h010);
    write_beat(1, 12'h2a8, 64'h5555_6666_7777_8888, 8'h3c);
    read_beat(1, 12'h2a8);
    finish_test("partial strobe");

    write_beat(0, 12'h120, 64'h0f1e_2d3c_4b5a_6978, 8'hff);
    read_beat(1, 12'h120);
    read_beat(1, 12'h128);
    finish_test("cross port");

    // Both writes land on banks 2 and 3 in the same cycle
    fork
      write_beat(0, 12'h208, 64'hdead_beef_cafe_f00d, 8'hff);
      write_beat(1, 12'h318, 64'h1234_abcd_5678_ef01, 8'hff);
    join
    read_beat(0, 12'h318);
    read_beat(1, 12'h208);
    finish_test("bank conflict");

    rand_mode = 1'b1;
    fork
      random_port(0, RAND_ACCESSES / 2);
      random_port(1, RAND_ACCESSES / 2);
    join
    rand_mode = 1'b0;
    finish_test("back-pressure");

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             test_num, fail_tests, check_cnt, total_errors());
    if (total_errors() == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
source/axi_mem_pkg.sv
source/access_chan_if.sv
source/bank_lane_if.sv
source/axi_port_split.sv
source/word_splitter.sv
source/bank_crossbar.sv
source/axi_banked_mem.sv
test/axi_banked_mem_chk.sv
test/tb_axi_banked_mem.sv

/* Makefile */
TOP = tb_axi_banked_mem
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -f files.f --Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
